// ==== include/fpu_defs.svh ====
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// depth of the floating register file
`define FPU_REG_COUNT 32

// issue to done, in cycles
`define FPU_LAT_SHORT 1
`define FPU_LAT_LONG 2

// implementation register returned on CFC1 $0, single format only
`define FPU_FIR_VALUE 32'h0001_0000

// default NaN words, NEG and ABS hand these back untouched
`define FPU_QNAN_A 32'h7fff_ffff
`define FPU_QNAN_B 32'h7fbf_ffff

`endif

// ==== source/fpu_pkg.sv ====
package fpu_pkg;

	typedef logic [31:0] word_t;

	typedef enum logic [4:0] {
		FPU_OP_NOP,
		FPU_OP_MFC,
		FPU_OP_CFC,
		FPU_OP_MTC,
		FPU_OP_CTC,
		FPU_OP_MOV,
		FPU_OP_NEG,
		FPU_OP_ABS,
		FPU_OP_COND,
		FPU_OP_ROUND,
		FPU_OP_TRUNC,
		FPU_OP_CEIL,
		FPU_OP_FLOOR,
		FPU_OP_CVTW,
		FPU_OP_INVALID
	} fpu_op_e;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] fmt;
		logic [4:0] ft;
		logic [4:0] fs;
		logic [4:0] fd;
		logic [5:0] funct;
	} cop1_arith_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  sub;
		logic [4:0]  rt;
		logic [4:0]  fs;
		logic [10:0] unused;
	} cop1_move_t;

	typedef union packed {
		cop1_arith_t arith;
		cop1_move_t  move;
	} fpu_inst_u;

	typedef struct packed {
		fpu_op_e    op;
		logic [4:0] fs;
		logic [4:0] ft;
		logic [4:0] fd;
		logic [4:0] ctrl; // control register number for CFC1/CTC1
		logic [3:0] cond;
		logic [2:0] cc;
	} fpu_uop_t;

	typedef struct packed {
		logic [7:0] fcc;
		logic       fs;
		logic [5:0] cause;
		logic [4:0] enables;
		logic [4:0] flags;
		logic [1:0] rm;
		logic [4:0] pad;
	} fcsr_t;

	// low five bits follow the flags order V Z O U I
	typedef struct packed {
		logic unimpl;
		logic invalid;
		logic divided_by_zero;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpu_except_t;

	typedef struct packed {
		logic        fpr_we;
		logic [4:0]  fpr_addr;
		word_t       fpr_data;
		logic        fcsr_we;
		fcsr_t       fcsr_data;
		logic        gpr_we;
		word_t       gpr_data;
		fpu_except_t except;
	} fpu_wb_t;

endpackage

// ==== source/fpu_decode.sv ====
module fpu_decode (
	input  fpu_pkg::word_t    inst,
	output fpu_pkg::fpu_uop_t uop
);
	import fpu_pkg::*;

	localparam logic [5:0] cop1_opcode = 6'b010001;
	localparam logic [4:0] fmt_single = 5'b10000;
	localparam logic [4:0] sub_mfc = 5'b00000;
	localparam logic [4:0] sub_cfc = 5'b00010;
	localparam logic [4:0] sub_mtc = 5'b00100;
	localparam logic [4:0] sub_ctc = 5'b00110;

	fpu_inst_u word;
	logic move_clean;

	assign word = inst;
	assign move_clean = word.move.unused == '0; // low bits must be zero in move forms

	always_comb
	begin
		uop.op = FPU_OP_NOP;
		uop.fs = word.arith.fs;
		uop.ft = word.arith.ft;
		uop.fd = word.arith.fd;
		uop.ctrl = word.move.fs;
		uop.cond = word.arith.funct[3:0];
		uop.cc = word.arith.fd[4:2];
		if (word.move.opcode == cop1_opcode)
		begin
			uop.op = FPU_OP_INVALID; // arithmetic cores are not present here
			if (word.arith.fmt == fmt_single)
			begin
				if (word.arith.funct[5:4] == 2'b11)
					uop.op = FPU_OP_COND;
				else
				begin
					case (word.arith.funct)
					6'h05: uop.op = FPU_OP_ABS;
					6'h06: uop.op = FPU_OP_MOV;
					6'h07: uop.op = FPU_OP_NEG;
					6'h0c: uop.op = FPU_OP_ROUND;
					6'h0d: uop.op = FPU_OP_TRUNC;
					6'h0e: uop.op = FPU_OP_CEIL;
					6'h0f: uop.op = FPU_OP_FLOOR;
					6'h24: uop.op = FPU_OP_CVTW;
					default: uop.op = FPU_OP_INVALID;
					endcase
				end
			end
			else if (move_clean)
			begin
				case (word.move.sub)
				sub_mfc: uop.op = FPU_OP_MFC;
				sub_cfc: uop.op = FPU_OP_CFC;
				sub_ctc: uop.op = FPU_OP_CTC;
				sub_mtc:
				begin
					uop.op = FPU_OP_MTC;
					uop.fd = word.move.fs; // target register sits in the fs slot
				end
				default: uop.op = FPU_OP_INVALID;
				endcase
			end
		end
	end

endmodule

// ==== source/fpu_float2int.sv ====
module fpu_float2int (
	input  fpu_pkg::word_t value,
	output fpu_pkg::word_t round_result,
	output fpu_pkg::word_t trunc_result,
	output fpu_pkg::word_t ceil_result,
	output fpu_pkg::word_t floor_result,
	output logic [3:0]     invalid
);

	logic        sign;
	logic [7:0]  exponent;
	logic [23:0] mantissa;
	logic [5:0]  shift;
	logic [63:0] fixed;
	logic [31:0] magnitude;
	logic        round_bit;
	logic        sticky;
	logic        inexact;
	logic        out_of_range;

	function automatic logic [31:0] finish(input logic [31:0] mag, input logic up,
		input logic neg, input logic sat);
		logic [31:0] total;
		total = mag + 32'(up);
		if (sat)
			return 32'h7fff_ffff;
		return neg ? -total : total;
	endfunction

	assign sign = value[31];
	assign exponent = value[30:23];
	assign mantissa = {1'b1, value[22:0]};

	// unbiased exponent 31 and up does not fit, except -2^31 itself
	assign out_of_range = exponent >= 8'd158 && value != 32'hcf00_0000;

	// integer part above bit 32, fraction below
	assign shift = 6'(8'd158 - exponent);
	assign fixed = {mantissa, 40'b0} >> shift;

	always_comb
	begin
		if (exponent < 8'd126)
		begin
			magnitude = '0; // below one half
			round_bit = 1'b0;
			sticky = |value[30:0];
		end
		else
		begin
			magnitude = fixed[63:32];
			round_bit = fixed[31];
			sticky = |fixed[30:0];
		end
	end

	assign inexact = round_bit | sticky;

	assign round_result = finish(magnitude, round_bit & (sticky | magnitude[0]), sign,
		out_of_range);
	assign trunc_result = finish(magnitude, 1'b0, sign, out_of_range);
	assign ceil_result = finish(magnitude, ~sign & inexact, sign, out_of_range);
	assign floor_result = finish(magnitude, sign & inexact, sign, out_of_range);

	assign invalid = {4{out_of_range}}; // bit 0 round .. bit 3 floor

endmodule

// ==== source/fpu_execute.sv ====
`include "fpu_defs.svh"

module fpu_execute (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue,
	input  logic              hold,
	input  logic              flush,
	input  fpu_pkg::fpu_uop_t uop,
	input  fpu_pkg::word_t    gpr_value,
	input  fpu_pkg::word_t    fs_value,
	input  fpu_pkg::word_t    ft_value,
	input  fpu_pkg::fcsr_t    fcsr,
	output logic              busy,
	output logic              done,
	output fpu_pkg::fpu_wb_t  wb
);
	import fpu_pkg::*;

	localparam int count_width = $clog2(`FPU_LAT_LONG + 1);

	logic                   active;
	logic [count_width-1:0] remaining;
	logic                   long_op;
	fpu_uop_t               uop_q;
	word_t                  gpr_q, fs_q, ft_q;
	word_t                  fs_in, ft_in;
	word_t                  conv_results [4];
	logic [3:0]             conv_invalid;
	logic [1:0]             conv_mode;
	logic                   fs_is_qnan;
	logic                   a_nan, b_nan, unordered, equal, less, match;
	logic [31:0]            a_key, b_key;
	logic [7:0]             fcc_next;
	logic                   arith, fpr_we_c, gpr_we_c, fcsr_we_c;
	word_t                  fpr_data_c, gpr_data_c;
	fcsr_t                  fcsr_next;
	fpu_except_t            except_c;

	assign long_op = uop.op inside {FPU_OP_COND, FPU_OP_ROUND, FPU_OP_TRUNC, FPU_OP_CEIL,
		FPU_OP_FLOOR, FPU_OP_CVTW};
	assign done = active && remaining == count_width'(1) && !hold && !flush;
	assign busy = active && !done;

	// a write completing in the issue cycle is not yet in the register file
	assign fs_in = (wb.fpr_we && wb.fpr_addr == uop.fs) ? wb.fpr_data : fs_value;
	assign ft_in = (wb.fpr_we && wb.fpr_addr == uop.ft) ? wb.fpr_data : ft_value;

	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			active <= 1'b0;
			remaining <= '0;
		end
		else if (issue)
		begin
			active <= 1'b1;
			remaining <= long_op ? count_width'(`FPU_LAT_LONG) : count_width'(`FPU_LAT_SHORT);
		end
		else if (done)
			active <= 1'b0;
		else if (active && !hold)
			remaining <= remaining - 1'b1; // frozen while the memory stage stalls
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			uop_q <= uop;
			gpr_q <= gpr_value;
			fs_q <= fs_in;
			ft_q <= ft_in;
		end
	end

	fpu_float2int float2int_inst (
		.value       (fs_q),
		.round_result(conv_results[0]),
		.trunc_result(conv_results[1]),
		.ceil_result (conv_results[2]),
		.floor_result(conv_results[3]),
		.invalid     (conv_invalid)
	);

	always_comb
	begin
		case (uop_q.op)
		FPU_OP_ROUND: conv_mode = 2'd0;
		FPU_OP_TRUNC: conv_mode = 2'd1;
		FPU_OP_CEIL: conv_mode = 2'd2;
		FPU_OP_FLOOR: conv_mode = 2'd3;
		default: conv_mode = fcsr.rm; // cvt.w
		endcase
	end

	assign fs_is_qnan = fs_q == `FPU_QNAN_A || fs_q == `FPU_QNAN_B;

	// compare on sign-magnitude keys, +0 and -0 are equal
	assign a_nan = &fs_q[30:23] && |fs_q[22:0];
	assign b_nan = &ft_q[30:23] && |ft_q[22:0];
	assign unordered = a_nan || b_nan;
	assign a_key = fs_q[31] ? ~fs_q : {1'b1, fs_q[30:0]};
	assign b_key = ft_q[31] ? ~ft_q : {1'b1, ft_q[30:0]};
	assign equal = !unordered && (fs_q == ft_q || (fs_q[30:0] == '0 && ft_q[30:0] == '0));
	assign less = !unordered && !equal && a_key < b_key;
	assign match = |({less, equal, unordered} & uop_q.cond[2:0]); // signalling bit ignored

	always_comb
	begin
		fcc_next = fcsr.fcc;
		fcc_next[uop_q.cc] = match;
	end

	always_comb
	begin
		arith = 1'b0;
		fpr_we_c = 1'b0;
		fpr_data_c = fs_q;
		gpr_we_c = 1'b0;
		gpr_data_c = '0;
		fcsr_we_c = 1'b0;
		fcsr_next = fcsr;
		except_c = '0;
		case (uop_q.op)
		FPU_OP_MFC:
		begin
			gpr_we_c = 1'b1;
			gpr_data_c = fs_q;
		end
		FPU_OP_MTC:
		begin
			fpr_we_c = 1'b1;
			fpr_data_c = gpr_q;
		end
		FPU_OP_MOV: fpr_we_c = 1'b1;
		FPU_OP_NEG, FPU_OP_ABS:
		begin
			arith = 1'b1;
			fpr_we_c = 1'b1;
			except_c.invalid = fs_is_qnan;
			if (!fs_is_qnan)
				fpr_data_c[31] = uop_q.op == FPU_OP_NEG ? ~fs_q[31] : 1'b0;
		end
		FPU_OP_ROUND, FPU_OP_TRUNC, FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_CVTW:
		begin
			arith = 1'b1;
			fpr_we_c = 1'b1;
			fpr_data_c = conv_results[conv_mode];
			except_c.invalid = conv_invalid[conv_mode];
		end
		FPU_OP_COND:
		begin
			fcsr_we_c = 1'b1;
			fcsr_next.fcc = fcc_next;
		end
		FPU_OP_CFC:
		begin
			gpr_we_c = 1'b1;
			case (uop_q.ctrl)
			5'd0: gpr_data_c = `FPU_FIR_VALUE;
			5'd25: gpr_data_c = {24'b0, fcsr.fcc};
			5'd26: gpr_data_c = {14'b0, fcsr.cause, 5'b0, fcsr.flags, 2'b0};
			5'd28: gpr_data_c = {20'b0, fcsr.enables, 4'b0, fcsr.fs, fcsr.rm};
			5'd31: gpr_data_c = {fcsr.fcc[7:1], fcsr.fs, fcsr.fcc[0], 5'b0,
				fcsr.cause, fcsr.enables, fcsr.flags, fcsr.rm};
			default: gpr_data_c = '0;
			endcase
		end
		FPU_OP_CTC:
		begin
			fcsr_we_c = 1'b1;
			case (uop_q.ctrl)
			5'd25: fcsr_next.fcc = gpr_q[7:0];
			5'd26:
			begin
				fcsr_next.cause = gpr_q[17:12];
				fcsr_next.flags = gpr_q[6:2];
			end
			5'd28:
			begin
				fcsr_next.enables = gpr_q[11:7];
				fcsr_next.fs = gpr_q[2];
				fcsr_next.rm = gpr_q[1:0];
			end
			5'd31:
			begin
				fcsr_next.fcc = {gpr_q[31:25], gpr_q[23]}; // fcc0 sits below fs
				fcsr_next.fs = gpr_q[24];
				fcsr_next.cause = gpr_q[17:12];
				fcsr_next.enables = gpr_q[11:7];
				fcsr_next.flags = gpr_q[6:2];
				fcsr_next.rm = gpr_q[1:0];
			end
			default: fcsr_we_c = 1'b0;
			endcase
		end
		FPU_OP_INVALID: except_c.unimpl = 1'b1;
		default: fpr_we_c = 1'b0;
		endcase
		if (arith)
		begin
			fcsr_we_c = 1'b1;
			fcsr_next.cause = except_c; // cause replaced, flags sticky
			fcsr_next.flags = fcsr.flags | except_c[4:0];
		end
		wb.fpr_we = done && fpr_we_c;
		wb.fpr_addr = uop_q.fd;
		wb.fpr_data = fpr_data_c;
		wb.fcsr_we = done && fcsr_we_c;
		wb.fcsr_data = fcsr_next;
		wb.gpr_we = done && gpr_we_c;
		wb.gpr_data = done ? gpr_data_c : '0;
		wb.except = done ? except_c : '0;
	end

endmodule

// ==== source/fpu_result.sv ====
`include "fpu_defs.svh"

module fpu_result (
	input  logic             clk,
	input  logic             reset,
	input  logic             done,
	input  fpu_pkg::fpu_wb_t wb,
	input  logic [4:0]       fs_addr,
	input  logic [4:0]       ft_addr,
	output fpu_pkg::word_t   fs_value,
	output fpu_pkg::word_t   ft_value,
	output fpu_pkg::fcsr_t   fcsr
);
	import fpu_pkg::*;

	word_t fpr [`FPU_REG_COUNT];

	// operands are read in the issue cycle
	assign fs_value = fpr[fs_addr];
	assign ft_value = fpr[ft_addr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `FPU_REG_COUNT; i++)
				fpr[i] <= '0;
		end
		else if (done && wb.fpr_we)
			fpr[wb.fpr_addr] <= wb.fpr_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			fcsr <= '0;
		else if (done && wb.fcsr_we)
			fcsr <= wb.fcsr_data; // whole word, fields merged upstream
	end

endmodule

// ==== source/fpu_top.sv ====
module fpu_top (
	input  logic                 clk,
	input  logic                 reset,
	input  fpu_pkg::word_t       inst,
	input  logic                 issue,
	input  fpu_pkg::word_t       gpr_value,
	input  logic                 hold,
	input  logic                 flush,
	output logic                 busy,
	output logic                 done,
	output logic                 gpr_we,
	output fpu_pkg::word_t       gpr_data,
	output fpu_pkg::fpu_except_t except
);
	import fpu_pkg::*;

	fpu_uop_t uop;
	word_t    fs_value;
	word_t    ft_value;
	fcsr_t    fcsr;
	fpu_wb_t  wb;

	fpu_decode decode_inst (
		.inst(inst),
		.uop (uop)
	);

	fpu_execute execute_inst (
		.clk      (clk),
		.reset    (reset),
		.issue    (issue),
		.hold     (hold),
		.flush    (flush),
		.uop      (uop),
		.gpr_value(gpr_value),
		.fs_value (fs_value),
		.ft_value (ft_value),
		.fcsr     (fcsr),
		.busy     (busy),
		.done     (done),
		.wb       (wb)
	);

	fpu_result result_inst (
		.clk     (clk),
		.reset   (reset),
		.done    (done),
		.wb      (wb),
		.fs_addr (uop.fs),
		.ft_addr (uop.ft),
		.fs_value(fs_value),
		.ft_value(ft_value),
		.fcsr    (fcsr)
	);

	// cpu side of the write-back
	assign gpr_we = wb.gpr_we;
	assign gpr_data = wb.gpr_data;
	assign except = wb.except;

endmodule

// ==== verification/fpu_tb.sv ====
`include "fpu_defs.svh"

module fpu_tb;
	import fpu_pkg::*;

	localparam logic [5:0] cop1 = 6'b010001;
	localparam logic [4:0] single = 5'b10000;

	logic        clk;
	logic        reset;
	word_t       inst;
	logic        issue;
	word_t       gpr_value;
	logic        hold;
	logic        flush;
	logic        busy;
	logic        done;
	logic        gpr_we;
	word_t       gpr_data;
	fpu_except_t except;

	word_t      lcg_state = 32'h182b;
	word_t      fpr_model [32];
	logic [7:0] m_fcc;
	logic       m_fs;
	logic [5:0] m_cause;
	logic [4:0] m_enables;
	logic [4:0] m_flags;
	logic [1:0] m_rm;

	int   cycle_count = 0;
	int   issued = 0;
	int   issue_cycle = 0;
	int   hold_seen = 0;
	int   lat_model = 0;
	logic pending = 1'b0;
	logic done_due;

	fpu_top fpu_top_inst (
		.clk      (clk),
		.reset    (reset),
		.inst     (inst),
		.issue    (issue),
		.gpr_value(gpr_value),
		.hold     (hold),
		.flush    (flush),
		.busy     (busy),
		.done     (done),
		.gpr_we   (gpr_we),
		.gpr_data (gpr_data),
		.except   (except)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// due when latency plus stalled cycles have passed since issue
	assign done_due = pending && !hold && !flush
		&& (cycle_count - issue_cycle - hold_seen == lat_model);

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (issue)
			issued <= issued + 1;
		if (reset || flush)
			pending <= 1'b0;
		else if (issue)
		begin
			pending <= 1'b1;
			issue_cycle <= cycle_count;
			hold_seen <= 0;
		end
		else if (done_due)
			pending <= 1'b0;
		else if (pending && hold)
			hold_seen <= hold_seen + 1;
		if (cycle_count > 40 * issued + 100)
		begin
			$display("Timeout: the DUT stopped finishing operations at cycle %0d", cycle_count);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	done_timing: assert property (@(posedge clk) disable iff (reset) done == done_due)
		else report_error("done is not in the cycle that latency and hold give");
	busy_level: assert property (@(posedge clk) disable iff (reset)
		busy == (pending && !done_due))
		else report_error("busy does not cover the pending operation");
	gpr_we_at_done: assert property (@(posedge clk) disable iff (reset) gpr_we |-> done)
		else report_error("gpr_we is high outside a done cycle");

	task automatic report_error(input string text);
		$display("Fail at time %0t: %s", $time, text);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input word_t got, input word_t expected);
		assert (got == expected)
		else report_error($sformatf("%s is %h, expected %h", what, got, expected));
	endtask

	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int latency_of(input fpu_op_e op);
		if (op inside {FPU_OP_COND, FPU_OP_ROUND, FPU_OP_TRUNC, FPU_OP_CEIL, FPU_OP_FLOOR,
			FPU_OP_CVTW})
			return `FPU_LAT_LONG;
		return `FPU_LAT_SHORT;
	endfunction

	function automatic word_t encode(input fpu_op_e op, input logic [4:0] fs,
		input logic [4:0] ft, input logic [4:0] fd, input logic [3:0] sel);
		case (op)
		FPU_OP_MFC: return {cop1, 5'b00000, 5'd2, fs, 11'd0};
		FPU_OP_CFC: return {cop1, 5'b00010, 5'd2, fs, 11'd0};
		FPU_OP_MTC: return {cop1, 5'b00100, 5'd2, fs, 11'd0};
		FPU_OP_CTC: return {cop1, 5'b00110, 5'd2, fs, 11'd0};
		FPU_OP_MOV: return {cop1, single, ft, fs, fd, 6'h06};
		FPU_OP_NEG: return {cop1, single, ft, fs, fd, 6'h07};
		FPU_OP_ABS: return {cop1, single, ft, fs, fd, 6'h05};
		FPU_OP_ROUND: return {cop1, single, ft, fs, fd, 6'h0c};
		FPU_OP_TRUNC: return {cop1, single, ft, fs, fd, 6'h0d};
		FPU_OP_CEIL: return {cop1, single, ft, fs, fd, 6'h0e};
		FPU_OP_FLOOR: return {cop1, single, ft, fs, fd, 6'h0f};
		FPU_OP_CVTW: return {cop1, single, ft, fs, fd, 6'h24};
		FPU_OP_COND: return {cop1, single, ft, fs, fd[2:0], 2'b00, 2'b11, sel};
		default: return {cop1, single, ft, fs, fd, 2'b00, sel}; // add.s .. div.s
		endcase
	endfunction

	function automatic logic is_nan(input word_t w);
		return w[30:23] == 8'hff && w[22:0] != '0;
	endfunction

	function automatic real to_real(input word_t w);
		if (w[30:23] == 8'd0)
			return 0.0; // zeros of either sign only
		return $bitstoreal({w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'b0});
	endfunction

	function automatic logic out_of_range(input word_t w);
		real x;
		x = to_real(w);
		return w[30:23] == 8'hff || x >= 2147483648.0 || x < -2147483648.0;
	endfunction

	function automatic word_t convert(input word_t w, input logic [1:0] mode);
		real x;
		real f;
		real r;
		if (out_of_range(w))
			return 32'h7fff_ffff;
		x = to_real(w);
		f = $floor(x);
		case (mode)
		2'd0:
		begin
			r = f;
			if (x - f > 0.5 || (x - f == 0.5 && $rtoi(f) % 2 != 0))
				r = f + 1.0; // ties go to even
		end
		2'd1: r = x < 0.0 ? $ceil(x) : f;
		2'd2: r = $ceil(x);
		default: r = f;
		endcase
		return word_t'($rtoi(r));
	endfunction

	function automatic word_t control_read(input logic [4:0] ctrl);
		case (ctrl)
		5'd0: return `FPU_FIR_VALUE;
		5'd25: return {24'b0, m_fcc};
		5'd26: return {14'b0, m_cause, 5'b0, m_flags, 2'b0};
		5'd28: return {20'b0, m_enables, 4'b0, m_fs, m_rm};
		5'd31: return {m_fcc[7:1], m_fs, m_fcc[0], 5'b0, m_cause, m_enables, m_flags, m_rm};
		default: return '0;
		endcase
	endfunction

	task automatic model_op(input fpu_op_e op, input logic [4:0] fs, input logic [4:0] ft,
		input logic [4:0] fd, input logic [3:0] sel, input word_t rt, output logic we,
		output word_t data, output logic [5:0] exc);
		word_t      v;
		word_t      w;
		logic       unordered;
		logic [2:0] hits;
		logic [1:0] mode;
		we = 1'b0;
		data = '0;
		exc = '0;
		v = fpr_model[fs];
		w = fpr_model[ft];
		case (op)
		FPU_OP_MFC:
		begin
			we = 1'b1;
			data = v;
		end
		FPU_OP_MTC: fpr_model[fs] = rt;
		FPU_OP_MOV: fpr_model[fd] = v;
		FPU_OP_NEG, FPU_OP_ABS:
		begin
			if (v == `FPU_QNAN_A || v == `FPU_QNAN_B)
				exc[4] = 1'b1;
			else
				v[31] = op == FPU_OP_NEG ? ~v[31] : 1'b0;
			fpr_model[fd] = v;
			m_cause = exc;
			m_flags = m_flags | exc[4:0];
		end
		FPU_OP_COND:
		begin
			unordered = is_nan(v) || is_nan(w);
			hits = {!unordered && to_real(v) < to_real(w),
				!unordered && to_real(v) == to_real(w), unordered};
			m_fcc[fd[2:0]] = |(hits & sel[2:0]);
		end
		FPU_OP_ROUND, FPU_OP_TRUNC, FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_CVTW:
		begin
			case (op)
			FPU_OP_ROUND: mode = 2'd0;
			FPU_OP_TRUNC: mode = 2'd1;
			FPU_OP_CEIL: mode = 2'd2;
			FPU_OP_FLOOR: mode = 2'd3;
			default: mode = m_rm;
			endcase
			exc[4] = out_of_range(v);
			fpr_model[fd] = convert(v, mode);
			m_cause = exc;
			m_flags = m_flags | exc[4:0];
		end
		FPU_OP_CFC:
		begin
			we = 1'b1;
			data = control_read(fs);
		end
		FPU_OP_CTC:
		begin
			if (fs == 5'd25 || fs == 5'd31)
				m_fcc = fs == 5'd25 ? rt[7:0] : {rt[31:25], rt[23]};
			if (fs == 5'd26 || fs == 5'd31)
			begin
				m_cause = rt[17:12];
				m_flags = rt[6:2];
			end
			if (fs == 5'd28 || fs == 5'd31)
			begin
				m_enables = rt[11:7];
				m_fs = fs == 5'd28 ? rt[2] : rt[24];
				m_rm = rt[1:0];
			end
		end
		default: exc[5] = 1'b1; // unimplemented
		endcase
	endtask

	task automatic start_op(input fpu_op_e op, input logic [4:0] fs, input logic [4:0] ft,
		input logic [4:0] fd, input logic [3:0] sel, input word_t rt);
		@(posedge clk);
		inst <= encode(op, fs, ft, fd, sel);
		gpr_value <= rt;
		issue <= 1'b1;
		lat_model <= latency_of(op);
	endtask

	task automatic run_op(input fpu_op_e op, input logic [4:0] fs, input logic [4:0] ft,
		input logic [4:0] fd, input logic [3:0] sel, input word_t rt, input int hold_len);
		logic       exp_we;
		word_t      exp_data;
		logic [5:0] exp_except;
		model_op(op, fs, ft, fd, sel, rt, exp_we, exp_data, exp_except);
		start_op(op, fs, ft, fd, sel, rt);
		@(posedge clk);
		issue <= 1'b0;
		hold <= hold_len > 0;
		repeat (hold_len) @(posedge clk);
		hold <= 1'b0;
		@(negedge clk);
		while (!done)
			@(negedge clk);
		check_value($sformatf("%s gpr_we", op.name()), {31'b0, gpr_we}, {31'b0, exp_we});
		if (exp_we)
			check_value($sformatf("%s gpr_data", op.name()), gpr_data, exp_data);
		check_value($sformatf("%s except", op.name()), {26'b0, except}, {26'b0, exp_except});
	endtask

	task automatic overlap_move(input logic [4:0] src, input logic [4:0] dst,
		input word_t value);
		logic       exp_we;
		word_t      exp_data;
		logic [5:0] exp_except;
		model_op(FPU_OP_MTC, src, 5'd0, 5'd0, 4'd0, value, exp_we, exp_data, exp_except);
		model_op(FPU_OP_MOV, src, 5'd0, dst, 4'd0, '0, exp_we, exp_data, exp_except);
		start_op(FPU_OP_MTC, src, 5'd0, 5'd0, 4'd0, value);
		start_op(FPU_OP_MOV, src, 5'd0, dst, 4'd0, '0); // issued in the MTC done cycle
		@(posedge clk);
		issue <= 1'b0;
		@(negedge clk);
		while (!done)
			@(negedge clk);
		check_value("overlapped MOV gpr_we", {31'b0, gpr_we}, 32'd0);
		check_value("overlapped MOV except", {26'b0, except}, 32'd0);
	endtask

	task automatic flush_op(input fpu_op_e op, input logic [4:0] fs, input logic [4:0] fd);
		start_op(op, fs, 5'd0, fd, 4'd0, '0);
		@(posedge clk);
		issue <= 1'b0;
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		repeat (`FPU_LAT_LONG + 2) @(posedge clk);
	endtask

	task automatic write_fpr(input logic [4:0] r, input word_t value);
		run_op(FPU_OP_MTC, r, 5'd0, 5'd0, 4'd0, value, 0);
	endtask

	task automatic read_fpr(input logic [4:0] r);
		run_op(FPU_OP_MFC, r, 5'd0, 5'd0, 4'd0, '0, 0);
	endtask

	task automatic write_ctrl(input logic [4:0] ctrl, input word_t value);
		run_op(FPU_OP_CTC, ctrl, 5'd0, 5'd0, 4'd0, value, 0);
	endtask

	task automatic read_ctrl(input logic [4:0] ctrl);
		run_op(FPU_OP_CFC, ctrl, 5'd0, 5'd0, 4'd0, '0, 0);
	endtask

	initial
	begin
		word_t      v;
		logic [4:0] a;
		logic [4:0] b;
		word_t      pair_a [5];
		word_t      pair_b [5];
		word_t      conv_in [9];
		fpu_op_e    conv_ops [4];
		inst = '0;
		issue = 1'b0;
		gpr_value = '0;
		hold = 1'b0;
		flush = 1'b0;
		reset = 1'b1;
		foreach (fpr_model[i])
			fpr_model[i] = '0;
		{m_fcc, m_fs, m_cause, m_enables, m_flags, m_rm} = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		repeat (4)
		begin
			a = 5'(next_random());
			b = a + 5'd1 + 5'(next_random() % 31);
			write_fpr(a, next_random());
			read_fpr(a);
			run_op(FPU_OP_MOV, a, 5'd0, b, 4'd0, '0, 0);
			read_fpr(b);
		end
		overlap_move(a, b, next_random());
		read_fpr(b);

		repeat (4)
		begin
			a = 5'(next_random());
			b = a + 5'd1 + 5'(next_random() % 31);
			v = next_random();
			v[30] = 1'b0; // keeps the exponent finite
			write_fpr(a, v);
			run_op(FPU_OP_NEG, a, 5'd0, b, 4'd0, '0, 0);
			read_fpr(b);
			run_op(FPU_OP_ABS, b, 5'd0, a, 4'd0, '0, 0);
			read_fpr(a);
		end
		write_fpr(5'd3, `FPU_QNAN_A);
		run_op(FPU_OP_NEG, 5'd3, 5'd0, 5'd4, 4'd0, '0, 0);
		read_fpr(5'd4);
		write_fpr(5'd5, `FPU_QNAN_B);
		run_op(FPU_OP_ABS, 5'd5, 5'd0, 5'd6, 4'd0, '0, 0);
		read_fpr(5'd6);
		read_ctrl(5'd26);

		// less, equal, greater, unordered, signed zeros
		pair_a = '{32'h3f80_0000, 32'h4000_0000, 32'h4040_0000, 32'h7fc0_0000, 32'h8000_0000};
		pair_b = '{32'h4000_0000, 32'h4000_0000, 32'hbf80_0000, 32'h3f80_0000, 32'h0000_0000};
		for (int p = 0; p < 5; p++)
		begin
			write_fpr(5'd1, pair_a[p]);
			write_fpr(5'd2, pair_b[p]);
			for (int c = 0; c < 16; c++)
			begin
				run_op(FPU_OP_COND, 5'd1, 5'd2, 5'(next_random() % 8), 4'(c), '0, 0);
				read_ctrl(5'd25);
			end
		end

		// halves, fractions, range limits and a NaN
		conv_in = '{32'h4020_0000, 32'h4060_0000, 32'hc020_0000, 32'h3fa0_0000, 32'hbfe0_0000,
			32'h3f00_0000, 32'h4f32_d05e, 32'hcf00_0000, 32'h7fc0_0000};
		conv_ops = '{FPU_OP_ROUND, FPU_OP_TRUNC, FPU_OP_CEIL, FPU_OP_FLOOR};
		foreach (conv_in[i])
		begin
			write_fpr(5'd7, conv_in[i]);
			foreach (conv_ops[k])
			begin
				run_op(conv_ops[k], 5'd7, 5'd0, 5'd8, 4'd0, '0, 0);
				read_fpr(5'd8);
			end
			for (int m = 0; m < 4; m++)
			begin
				write_ctrl(5'd28, word_t'(m));
				run_op(FPU_OP_CVTW, 5'd7, 5'd0, 5'd8, 4'd0, '0, 0);
				read_fpr(5'd8);
			end
			read_ctrl(5'd26);
		end

		repeat (4)
		begin
			write_ctrl(5'd31, next_random());
			read_ctrl(5'd31);
		end
		read_ctrl(5'd0);
		read_ctrl(5'd1);
		write_fpr(5'd9, next_random());
		run_op(FPU_OP_INVALID, 5'd7, 5'd8, 5'd9, 4'd0, '0, 0); // add.s
		run_op(FPU_OP_INVALID, 5'd7, 5'd8, 5'd9, 4'd3, '0, 0); // div.s
		read_fpr(5'd9);
		read_ctrl(5'd31);

		repeat (6)
		begin
			a = 5'(next_random());
			b = a + 5'd1 + 5'(next_random() % 31);
			v = next_random();
			v[30] = 1'b0;
			run_op(FPU_OP_MTC, a, 5'd0, 5'd0, 4'd0, v, int'(next_random() % 5));
			run_op(FPU_OP_NEG, a, 5'd0, b, 4'd0, '0, int'(next_random() % 5));
			read_fpr(b);
			run_op(FPU_OP_TRUNC, a, 5'd0, b, 4'd0, '0, int'(next_random() % 5));
			read_fpr(b);
		end
		write_fpr(5'd10, 32'h4120_0000);
		write_fpr(5'd11, 32'h1234_5678);
		flush_op(FPU_OP_TRUNC, 5'd10, 5'd11);
		read_fpr(5'd11);
		read_ctrl(5'd31);

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
source/fpu_pkg.sv
source/fpu_decode.sv
source/fpu_float2int.sv
source/fpu_execute.sv
source/fpu_result.sv
source/fpu_top.sv
verification/fpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = fpu_tb
FILELIST = project.f
BUILD_DIR = obj_dir
BIN = $(BUILD_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(wildcard include/*.svh source/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
